// ==== logic/cam_pkg.sv ====
`default_nettype none

// shared frame geometry and bus types for the camera capture path
package cam_pkg;

  // active 720p frame
  localparam int FRAME_WIDTH  = 1280;
  localparam int FRAME_HEIGHT = 720;

  // two-flop synchronizer on the camera pins
  localparam int SYNC_STAGES = 2;

  // one 128-bit memory word holds eight pixels
  localparam int PIXELS_PER_CHUNK = 8;

  // rgb565
  typedef logic [15:0] pixel_t;

  typedef logic [$clog2(FRAME_WIDTH)-1:0]  hcount_t;
  typedef logic [$clog2(FRAME_HEIGHT)-1:0] vcount_t;
  typedef logic [7:0]                      cam_byte_t;

  // lane 0 sits in bits 15:0
  typedef pixel_t [PIXELS_PER_CHUNK-1:0] chunk_t;

  // ddr word address, same width as the mig port
  typedef logic [26:0] chunk_addr_t;

  typedef logic [$clog2(PIXELS_PER_CHUNK)-1:0] lane_idx_t;

endpackage

`default_nettype wire

// ==== logic/pixel_stream_if.sv ====
`default_nettype none

// reconstructed pixel stream, one-cycle valid strobe, no back-pressure
interface pixel_stream_if import cam_pkg::*; ();

  logic    valid;
  hcount_t hcount;
  vcount_t vcount;
  pixel_t  data;

  // driven by the reconstruction stage
  modport source (output valid, output hcount, output vcount, output data);

  // sink must take the pixel in the cycle it shows up
  modport sink (input valid, input hcount, input vcount, input data);

endinterface

`default_nettype wire

// ==== logic/pixel_reconstruct.sv ====
`default_nettype none

module pixel_reconstruct import cam_pkg::*; (
  input  logic      clk_camera,
  input  logic      recent_reset,
  input  cam_byte_t camera_d_i,
  input  logic      cam_pclk_i,
  input  logic      cam_hsync_i,
  input  logic      cam_vsync_i,
  pixel_stream_if.source pix_o
);

  // synchronizer chains, index SYNC_STAGES-1 is the settled value
  cam_byte_t [SYNC_STAGES-1:0] d_sync;
  logic [SYNC_STAGES-1:0]      pclk_sync;
  logic [SYNC_STAGES-1:0]      hs_sync;
  logic [SYNC_STAGES-1:0]      vs_sync;

  // edge-detect stage, all aligned to the registered pclk edge
  logic      pclk_prev;
  logic      edge_q;
  cam_byte_t d_q;
  logic      hs_q;
  logic      hs_prev;
  logic      vs_q;

  logic      hs_fall;
  logic      capture;

  // byte pairing and counters
  logic      phase;
  cam_byte_t upper_q;
  hcount_t   hcount_cnt;
  vcount_t   vcount_cnt;

  // output registers
  logic      valid_q;
  pixel_t    data_q;
  hcount_t   hcount_q;
  vcount_t   vcount_q;

  always_ff @(posedge clk_camera) begin
    d_sync    <= {d_sync[SYNC_STAGES-2:0], camera_d_i};
    pclk_sync <= {pclk_sync[SYNC_STAGES-2:0], cam_pclk_i};
    hs_sync   <= {hs_sync[SYNC_STAGES-2:0], cam_hsync_i};
    vs_sync   <= {vs_sync[SYNC_STAGES-2:0], cam_vsync_i};
  end

  // one cycle after synced pclk goes high the edge flag is up
  always_ff @(posedge clk_camera) begin
    pclk_prev <= pclk_sync[SYNC_STAGES-1];
    d_q       <= d_sync[SYNC_STAGES-1];
    hs_q      <= hs_sync[SYNC_STAGES-1];
    hs_prev   <= hs_q;
    vs_q      <= vs_sync[SYNC_STAGES-1];
    if (recent_reset) begin
      edge_q <= 1'b0;
    end else begin
      edge_q <= pclk_sync[SYNC_STAGES-1] & ~pclk_prev;
    end
  end

  assign hs_fall = hs_prev & ~hs_q;
  // bytes only count inside an active line and outside vsync
  assign capture = edge_q & hs_q & ~vs_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      phase      <= 1'b0;
      hcount_cnt <= '0;
      vcount_cnt <= '0;
      valid_q    <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (vs_q) begin
        // new frame
        phase      <= 1'b0;
        hcount_cnt <= '0;
        vcount_cnt <= '0;
      end else if (hs_fall) begin
        // end of line
        phase      <= 1'b0;
        hcount_cnt <= '0;
        vcount_cnt <= vcount_cnt + 1'b1;
      end else if (capture) begin
        phase <= ~phase;
        if (phase) begin
          valid_q    <= 1'b1;
          hcount_cnt <= hcount_cnt + 1'b1;
        end
      end
    end
  end

  // first byte is the upper half of the pixel
  always_ff @(posedge clk_camera) begin
    if (capture) begin
      if (!phase) begin
        upper_q <= d_q;
      end else begin
        data_q   <= {upper_q, d_q};
        hcount_q <= hcount_cnt;
        vcount_q <= vcount_cnt;
      end
    end
  end

  assign pix_o.valid  = valid_q;
  assign pix_o.data   = data_q;
  assign pix_o.hcount = hcount_q;
  assign pix_o.vcount = vcount_q;

  // two bytes per pixel, so strobes are never back to back
  a_valid_spaced: assert property (@(posedge clk_camera) disable iff (recent_reset)
    valid_q |=> !valid_q);

endmodule

`default_nettype wire

// ==== logic/pixel_stacker.sv ====
`default_nettype none

module pixel_stacker import cam_pkg::*; (
  input  logic   clk_camera,
  input  logic   recent_reset,
  pixel_stream_if.sink pix_i,
  input  logic   chunk_ready_i,
  output logic   chunk_valid_o,
  output logic   chunk_last_o,
  output logic   overflow_o,
  output chunk_t chunk_data_o
);

  // accumulator, lanes below lane hold this chunk's pixels
  chunk_t    acc;
  lane_idx_t lane;

  logic      frame_end;
  logic      chunk_done;
  logic      out_free;
  logic      load;
  chunk_t    closed_chunk;

  // pixel (1279, 719) ends the frame
  assign frame_end = (pix_i.hcount == hcount_t'(FRAME_WIDTH - 1)) &&
                     (pix_i.vcount == vcount_t'(FRAME_HEIGHT - 1));

  assign chunk_done = pix_i.valid &&
                      ((lane == lane_idx_t'(PIXELS_PER_CHUNK - 1)) || frame_end);

  // output register empty, or emptied this cycle
  assign out_free = !chunk_valid_o || chunk_ready_i;
  assign load     = chunk_done && out_free;

  // current pixel goes in its lane, lanes above it read as zero
  always_comb begin
    closed_chunk = '0;
    for (int i = 0; i < PIXELS_PER_CHUNK; i++) begin
      if (i < int'(lane)) begin
        closed_chunk[i] = acc[i];
      end
    end
    closed_chunk[lane] = pix_i.data;
  end

  always_ff @(posedge clk_camera) begin
    if (pix_i.valid) begin
      acc[lane] <= pix_i.data;
    end
  end

  // lane count restarts on every close, full or early
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      lane <= '0;
    end else if (pix_i.valid) begin
      lane <= chunk_done ? '0 : lane + 1'b1;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      chunk_valid_o <= 1'b0;
      chunk_last_o  <= 1'b0;
      overflow_o    <= 1'b0;
    end else begin
      if (load) begin
        chunk_valid_o <= 1'b1;
        chunk_last_o  <= frame_end;
      end else if (chunk_ready_i) begin
        chunk_valid_o <= 1'b0;
      end
      // held chunk stays, the new one is lost
      if (chunk_done && !out_free) begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (load) begin
      chunk_data_o <= closed_chunk;
    end
  end

  // stream rule, payload frozen while stalled
  a_data_held: assert property (@(posedge clk_camera) disable iff (recent_reset)
    (chunk_valid_o && !chunk_ready_i) |=> $stable(chunk_data_o));

endmodule

`default_nettype wire

// ==== logic/chunk_addr_gen.sv ====
`default_nettype none

module chunk_addr_gen import cam_pkg::*; (
  input  logic        clk_camera,
  input  logic        recent_reset,
  input  logic        accept_i,
  input  logic        last_i,
  output chunk_addr_t chunk_addr_o
);

  // word address of the chunk now at the output
  chunk_addr_t addr_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      addr_q <= '0;
    end else if (accept_i) begin
      // frame done, next frame starts at word 0
      if (last_i) begin
        addr_q <= '0;
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign chunk_addr_o = addr_q;

  // dropped chunks never reach accept, so no gaps in the sequence
  a_addr_only_on_accept: assert property (@(posedge clk_camera) disable iff (recent_reset)
    !accept_i |=> $stable(chunk_addr_o));

endmodule

`default_nettype wire

// ==== logic/camera_capture.sv ====
`default_nettype none

module camera_capture import cam_pkg::*; (
  input  logic        clk_camera,
  input  logic        recent_reset,
  // parallel camera bus
  input  cam_byte_t   camera_d_i,
  input  logic        cam_pclk_i,
  input  logic        cam_hsync_i,
  input  logic        cam_vsync_i,
  // chunk stream toward memory
  input  logic        chunk_ready_i,
  output logic        chunk_valid_o,
  output logic        chunk_last_o,
  output logic        overflow_o,
  output chunk_t      chunk_data_o,
  output chunk_addr_t chunk_addr_o
);

  // pixels from reconstruction to stacker
  pixel_stream_if pix_bus ();

  // one chunk leaves per valid and ready
  logic chunk_accept;

  assign chunk_accept = chunk_valid_o & chunk_ready_i;

  pixel_reconstruct u_reconstruct (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .camera_d_i   (camera_d_i),
    .cam_pclk_i   (cam_pclk_i),
    .cam_hsync_i  (cam_hsync_i),
    .cam_vsync_i  (cam_vsync_i),
    .pix_o        (pix_bus.source)
  );

  pixel_stacker u_stacker (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pix_i         (pix_bus.sink),
    .chunk_ready_i (chunk_ready_i),
    .chunk_valid_o (chunk_valid_o),
    .chunk_last_o  (chunk_last_o),
    .overflow_o    (overflow_o),
    .chunk_data_o  (chunk_data_o)
  );

  // address follows the accepted chunk, last wraps it
  chunk_addr_gen u_addr_gen (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .accept_i     (chunk_accept),
    .last_i       (chunk_last_o),
    .chunk_addr_o (chunk_addr_o)
  );

endmodule

`default_nettype wire

// ==== tb/camera_capture_tb.sv ====
`default_nettype none

module camera_capture_tb import cam_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  // pclk high and low phases, four clk_camera cycles per byte
  localparam int PCLK_HALF    = 2;
  localparam int PACK_LINES   = 6;
  localparam int BP_LINES     = 12;
  localparam int OVF_PIXELS   = 24;
  localparam int GAP_LONG     = 80;
  localparam int TOTAL_PIXELS = PACK_LINES * 32 + BP_LINES * 8 + OVF_PIXELS +
                                (FRAME_HEIGHT - 1) * 3 + FRAME_WIDTH + 16;
  localparam int TOTAL_LINES  = PACK_LINES + BP_LINES + 1 + FRAME_HEIGHT + 2;
  // eight cycles per pixel, worst-case blanking per line, plus margin
  localparam int LIMIT_CYCLES = TOTAL_PIXELS * 8 + TOTAL_LINES * GAP_LONG + 4000;

  logic        clk_camera;
  logic        recent_reset;
  cam_byte_t   camera_d;
  logic        cam_pclk;
  logic        cam_hsync;
  logic        cam_vsync;
  logic        chunk_ready;
  logic        chunk_valid;
  logic        chunk_last;
  logic        overflow;
  chunk_t      chunk_data;
  chunk_addr_t chunk_addr;

  // 0 ready low, 1 ready high, 2 random ready
  logic [1:0]  ready_mode;
  string       test_name;
  int          last_count = 0;

  // reference model state and expected chunk stream
  chunk_t      exp_data[$];
  logic        exp_last[$];
  chunk_addr_t exp_addr[$];
  chunk_t      m_acc;
  int          m_lane;
  chunk_addr_t m_addr;
  int          m_hcount;
  int          m_vcount;

  camera_capture dut0 (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .camera_d_i    (camera_d),
    .cam_pclk_i    (cam_pclk),
    .cam_hsync_i   (cam_hsync),
    .cam_vsync_i   (cam_vsync),
    .chunk_ready_i (chunk_ready),
    .chunk_valid_o (chunk_valid),
    .chunk_last_o  (chunk_last),
    .overflow_o    (overflow),
    .chunk_data_o  (chunk_data),
    .chunk_addr_o  (chunk_addr)
  );

  initial begin
    clk_camera = 1'b0;
    forever #(CLK_PERIOD / 2) clk_camera = ~clk_camera;
  end

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(string what, logic [127:0] expected, logic [127:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("Test failures found");
      $fatal(1, "first mismatch");
    end
  endtask

  // n rising edges, then the small drive offset
  task automatic tick(int n);
    repeat (n) begin
      @(posedge clk_camera);
      #1;
    end
  endtask

  task automatic model_clear();
    exp_data.delete();
    exp_last.delete();
    exp_addr.delete();
    m_acc    = '0;
    m_lane   = 0;
    m_addr   = '0;
    m_hcount = 0;
    m_vcount = 0;
  endtask

  // eight pixels per chunk, frame-end pixel closes early and wraps the address
  task automatic model_pixel(pixel_t p);
    logic frame_end;
    frame_end = (m_hcount == FRAME_WIDTH - 1) && (m_vcount == FRAME_HEIGHT - 1);
    m_acc[m_lane] = p;
    m_lane++;
    if (m_lane == PIXELS_PER_CHUNK || frame_end) begin
      exp_data.push_back(m_acc);
      exp_last.push_back(frame_end);
      exp_addr.push_back(m_addr);
      m_addr = frame_end ? chunk_addr_t'(0) : m_addr + 1'b1;
      m_acc  = '0;
      m_lane = 0;
    end
    m_hcount++;
  endtask

  task automatic apply_reset();
    recent_reset = 1'b1;
    tick(RESET_CYCLES);
    recent_reset = 1'b0;
    model_clear();
  endtask

  // data set up while pclk is low, sampled on the rising edge
  task automatic send_byte(cam_byte_t b);
    cam_pclk = 1'b0;
    camera_d = b;
    tick(PCLK_HALF);
    cam_pclk = 1'b1;
    tick(PCLK_HALF);
  endtask

  task automatic send_line(int npix, int gap);
    cam_byte_t hi;
    cam_byte_t lo;
    cam_hsync = 1'b1;
    for (int i = 0; i < npix; i++) begin
      hi = cam_byte_t'($urandom);
      lo = cam_byte_t'($urandom);
      send_byte(hi);
      send_byte(lo);
      // upper byte comes first on the bus
      model_pixel({hi, lo});
    end
    cam_pclk  = 1'b0;
    cam_hsync = 1'b0;
    tick(gap);
    m_hcount = 0;
    m_vcount++;
  endtask

  task automatic vsync_pulse();
    cam_vsync = 1'b1;
    tick(6);
    cam_vsync = 1'b0;
    tick(4);
    m_hcount = 0;
    m_vcount = 0;
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) begin
      tick(1);
    end
    tick(4);
  endtask

  // ready driven later than the main stimulus so random draws keep their order
  initial begin : ready_driver
    chunk_ready = 1'b0;
    forever begin
      @(posedge clk_camera);
      #2;
      case (ready_mode)
        2'd0:    chunk_ready = 1'b0;
        2'd1:    chunk_ready = 1'b1;
        default: chunk_ready = ($urandom_range(0, 1) == 1);
      endcase
    end
  end

  // sampled mid-cycle, a transfer happens at the next rising edge
  always @(negedge clk_camera) begin : monitor
    chunk_t      want_data;
    logic        want_last;
    chunk_addr_t want_addr;
    if (!recent_reset && chunk_valid && chunk_ready) begin
      if (exp_data.size() == 0) begin
        abort_run($sformatf("unexpected chunk accepted at address %0d", chunk_addr));
      end else begin
        want_data = exp_data.pop_front();
        want_last = exp_last.pop_front();
        want_addr = exp_addr.pop_front();
        check_value("chunk data", 128'(want_data), 128'(chunk_data));
        check_value("chunk last", 128'(want_last), 128'(chunk_last));
        check_value("chunk addr", 128'(want_addr), 128'(chunk_addr));
        if (chunk_last) begin
          last_count++;
        end
      end
    end
  end

  initial begin : watchdog
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("timeout, no result after %0d clock cycles", LIMIT_CYCLES);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    int k;
    int gap;
    void'($urandom(32'h2b09_8524));
    recent_reset = 1'b1;
    camera_d     = '0;
    cam_pclk     = 1'b0;
    cam_hsync    = 1'b0;
    cam_vsync    = 1'b0;
    ready_mode   = 2'd0;
    test_name    = "reset";
    model_clear();
    tick(RESET_CYCLES);
    recent_reset = 1'b0;

    check_value("valid", 128'(0), 128'(chunk_valid));
    check_value("last", 128'(0), 128'(chunk_last));
    check_value("overflow", 128'(0), 128'(overflow));
    check_value("addr", 128'(0), 128'(chunk_addr));

    // lines of whole chunks, ready always high
    test_name  = "packing";
    ready_mode = 2'd1;
    for (int line = 0; line < PACK_LINES; line++) begin
      k   = $urandom_range(1, 4);
      gap = $urandom_range(4, 12);
      send_line(8 * k, gap);
    end
    wait_drain();
    check_value("overflow", 128'(0), 128'(overflow));

    // one chunk per line, blanking longer than a chunk takes to pack
    test_name  = "backpressure";
    ready_mode = 2'd2;
    for (int line = 0; line < BP_LINES; line++) begin
      send_line(8, GAP_LONG);
    end
    ready_mode = 2'd1;
    wait_drain();
    check_value("overflow", 128'(0), 128'(overflow));

    // three chunks packed against a stalled output
    test_name  = "overflow";
    ready_mode = 2'd0;
    apply_reset();
    send_line(OVF_PIXELS, 4);
    tick(16);
    check_value("valid held", 128'(1), 128'(chunk_valid));
    check_value("held addr", 128'(0), 128'(chunk_addr));
    check_value("held data", 128'(exp_data[0]), 128'(chunk_data));
    check_value("held last", 128'(0), 128'(chunk_last));
    check_value("overflow set", 128'(1), 128'(overflow));
    apply_reset();
    ready_mode = 2'd1;
    tick(4);
    check_value("overflow after reset", 128'(0), 128'(overflow));
    check_value("valid after reset", 128'(0), 128'(chunk_valid));

    // short lines up to the last one, then a full last line
    test_name = "frame end";
    // one line first so the line count is nonzero when vsync arrives
    send_line(8, 4);
    vsync_pulse();
    for (int line = 0; line < FRAME_HEIGHT - 1; line++) begin
      send_line(3, 4);
    end
    send_line(FRAME_WIDTH, 4);
    // first chunk of the next frame
    send_line(8, 4);
    wait_drain();
    check_value("last chunk count", 128'(1), 128'(last_count));
    check_value("overflow", 128'(0), 128'(overflow));

    test_name = "end";
    if (exp_data.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("%0d expected chunks never left the DUT", exp_data.size());
      $display("Test failures found");
      $fatal(1, "chunks missing");
    end
  end

endmodule

`default_nettype wire

// ==== build.f ====
logic/cam_pkg.sv
logic/pixel_stream_if.sv
logic/pixel_reconstruct.sv
logic/pixel_stacker.sv
logic/chunk_addr_gen.sv
logic/camera_capture.sv
tb/camera_capture_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the camera capture testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f build.f \
  --top-module camera_capture_tb -o camera_capture_sim

# the simulator exits non-zero on fatal, the log decides the result
./obj_dir/camera_capture_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
